// ==== common/memDefines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// bus and address widths
`define ADDR_W 32
`define DATA_W 32

// one select bit per byte lane
`define SEL_W 4

// kseg style translation clears this many top bits
`define SEG_BITS 3

`endif

// ==== common/memPkg.sv ====
package memPkg;

	// width of a load or store
	typedef enum logic [1:0] {
		accByte = 2'b00,
		accHalf = 2'b01,
		accWord = 2'b10
	} accSize_t;

endpackage

// ==== design/memAccessUnit.sv ====
`include "memDefines.svh"

module memAccessUnit (
	input  logic                clk,
	input  logic                rst,

	// pipeline side
	input  logic                reqValid,
	input  logic                reqWrite,
	input  memPkg::accSize_t    reqSize,
	input  logic                reqSigned,
	input  logic [`ADDR_W-1:0]  reqAddr,
	input  logic [`DATA_W-1:0]  reqData,
	output logic                busy,
	output logic                respValid,
	output logic [`DATA_W-1:0]  respData,

	// wishbone side
	output logic                wbCyc,
	output logic                wbStb,
	output logic                wbWe,
	output logic [`ADDR_W-1:0]  wbAdr,
	output logic [`SEL_W-1:0]   wbSel,
	output logic [`DATA_W-1:0]  wbDatW,
	input  logic [`DATA_W-1:0]  wbDatR,
	input  logic                wbAck
);

	logic [`SEL_W-1:0]  laneSel;
	logic [`DATA_W-1:0] laneData;
	memPkg::accSize_t   heldSize;
	logic               heldSigned;
	logic [1:0]         heldLow;
	logic [`DATA_W-1:0] readWord;

	// lanes from the live request
	storeLanes storeLanes_inst (
		.size    (reqSize),
		.addrLow (reqAddr[1:0]),
		.write   (reqWrite),
		.dataIn  (reqData),
		.sel     (laneSel),
		.dataOut (laneData)
	);

	wbMaster wbMaster_inst (
		.clk        (clk),
		.rst        (rst),
		.reqValid   (reqValid),
		.reqWrite   (reqWrite),
		.reqSize    (reqSize),
		.reqSigned  (reqSigned),
		.reqAddr    (reqAddr),
		.laneSel    (laneSel),
		.laneData   (laneData),
		.busy       (busy),
		.respValid  (respValid),
		.heldSize   (heldSize),
		.heldSigned (heldSigned),
		.heldLow    (heldLow),
		.readWord   (readWord),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.wbWe       (wbWe),
		.wbAdr      (wbAdr),
		.wbSel      (wbSel),
		.wbDatW     (wbDatW),
		.wbDatR     (wbDatR),
		.wbAck      (wbAck)
	);

	// load result from the registered request fields
	loadAlign loadAlign_inst (
		.size       (heldSize),
		.signedLoad (heldSigned),
		.addrLow    (heldLow),
		.word       (readWord),
		.data       (respData)
	);

endmodule

// ==== filelist.f ====
+incdir+common
+incdir+verif
common/memPkg.sv
memAccess/storeLanes.sv
memAccess/loadAlign.sv
memAccess/wbMaster.sv
design/memAccessUnit.sv
verif/memAccessUnitTb.sv

// ==== memAccess/loadAlign.sv ====
`include "memDefines.svh"

module loadAlign (
	input  memPkg::accSize_t    size,
	input  logic                signedLoad,
	input  logic [1:0]          addrLow,
	input  logic [`DATA_W-1:0]  word,
	output logic [`DATA_W-1:0]  data
);

	logic [7:0]  pickedByte;
	logic [15:0] pickedHalf;
	logic        byteSign;
	logic        halfSign;

	// lane extraction
	always_comb begin
		pickedByte = 8'(word >> {addrLow, 3'b000});
		if (addrLow[1]) begin
			pickedHalf = word[31:16];
		end else begin
			pickedHalf = word[15:0];
		end
	end

	// extension bits, zero for unsigned loads
	assign byteSign = signedLoad & pickedByte[7];
	assign halfSign = signedLoad & pickedHalf[15];

	always_comb begin
		case (size)
			memPkg::accByte: begin
				data = {{(`DATA_W-8){byteSign}}, pickedByte};
			end
			memPkg::accHalf: begin
				data = {{(`DATA_W-16){halfSign}}, pickedHalf};
			end
			memPkg::accWord: begin
				data = word;
			end
			default: begin
				data = word;
			end
		endcase
	end

endmodule

// ==== memAccess/storeLanes.sv ====
`include "memDefines.svh"

module storeLanes (
	input  memPkg::accSize_t    size,
	input  logic [1:0]          addrLow,
	input  logic                write,
	input  logic [`DATA_W-1:0]  dataIn,
	output logic [`SEL_W-1:0]   sel,
	output logic [`DATA_W-1:0]  dataOut
);

	logic [`DATA_W-1:0] placed;

	always_comb begin
		sel = '0;
		placed = '0;
		case (size)
			memPkg::accByte: begin
				// one lane with the byte copied everywhere
				sel = `SEL_W'(1) << addrLow;
				placed = {4{dataIn[7:0]}};
			end
			memPkg::accHalf: begin
				if (addrLow[1]) begin
					sel = 4'b1100;
				end else begin
					sel = 4'b0011;
				end
				placed = {2{dataIn[15:0]}};
			end
			memPkg::accWord: begin
				sel = '1;
				placed = dataIn;
			end
			default: begin
				// unused encoding behaves as a word
				sel = '1;
				placed = dataIn;
			end
		endcase

		// keep write data quiet on reads
		if (write) begin
			dataOut = placed;
		end else begin
			dataOut = '0;
		end
	end

endmodule

// ==== memAccess/wbMaster.sv ====
`include "memDefines.svh"

module wbMaster (
	input  logic                clk,
	input  logic                rst,

	// pipeline request
	input  logic                reqValid,
	input  logic                reqWrite,
	input  memPkg::accSize_t    reqSize,
	input  logic                reqSigned,
	input  logic [`ADDR_W-1:0]  reqAddr,
	input  logic [`SEL_W-1:0]   laneSel,
	input  logic [`DATA_W-1:0]  laneData,

	// pipeline response and held load fields
	output logic                busy,
	output logic                respValid,
	output memPkg::accSize_t    heldSize,
	output logic                heldSigned,
	output logic [1:0]          heldLow,
	output logic [`DATA_W-1:0]  readWord,

	// wishbone classic master
	output logic                wbCyc,
	output logic                wbStb,
	output logic                wbWe,
	output logic [`ADDR_W-1:0]  wbAdr,
	output logic [`SEL_W-1:0]   wbSel,
	output logic [`DATA_W-1:0]  wbDatW,
	input  logic [`DATA_W-1:0]  wbDatR,
	input  logic                wbAck
);

	logic               accept;
	logic               cycDone;
	logic [`ADDR_W-1:0] physAddr;

	assign accept = reqValid && !busy;
	assign cycDone = wbCyc && wbAck;

	// drop the segment bits and word align
	assign physAddr = {{`SEG_BITS{1'b0}}, reqAddr[`ADDR_W-`SEG_BITS-1:2], 2'b00};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe <= 1'b0;
			respValid <= 1'b0;
		end else begin
			respValid <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				wbCyc <= 1'b1;
				wbStb <= 1'b1;
				wbWe <= reqWrite;
			end else if (cycDone) begin
				// slave done so release the bus and answer
				busy <= 1'b0;
				wbCyc <= 1'b0;
				wbStb <= 1'b0;
				wbWe <= 1'b0;
				respValid <= 1'b1;
			end
		end
	end

	// request payload held for the whole bus cycle
	always_ff @(posedge clk) begin
		if (accept) begin
			wbAdr <= physAddr;
			wbSel <= laneSel;
			wbDatW <= laneData;
			heldSize <= reqSize;
			heldSigned <= reqSigned;
			heldLow <= reqAddr[1:0];
		end
	end

	// load data is only meaningful on reads
	always_ff @(posedge clk) begin
		if (cycDone && !wbWe) begin
			readWord <= wbDatR;
		end
	end

	// request must not move while the slave stalls
	reqStable: assert property (@(posedge clk) disable iff (rst)
		wbStb && !wbAck |=> $stable(wbAdr) && $stable(wbSel))
		else $error("wbMaster: address or select changed before ack");

	respPulse: assert property (@(posedge clk) disable iff (rst)
		respValid |=> !respValid)
		else $error("wbMaster: respValid held for more than one cycle");

endmodule

// ==== run.sh ====
#!/bin/sh
# compile and run the memory access unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module memAccessUnitTb -o memAccessSim \
	&& ./obj_dir/memAccessSim | tee /dev/stderr | grep -q "^TEST OK$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== verif/memAccessTests.svh ====
`ifndef MEM_ACCESS_TESTS_SVH
`define MEM_ACCESS_TESTS_SVH

// expected select, one lane per byte touched
function automatic logic [`SEL_W-1:0] laneMask(memPkg::accSize_t size, logic [1:0] low);
	laneMask = 4'b1111;
	if (size == memPkg::accByte) begin
		case (low)
			2'd0: laneMask = 4'b0001;
			2'd1: laneMask = 4'b0010;
			2'd2: laneMask = 4'b0100;
			default: laneMask = 4'b1000;
		endcase
	end else if (size == memPkg::accHalf) begin
		laneMask = low[1] ? 4'b1100 : 4'b0011;
	end
endfunction

function automatic logic [`DATA_W-1:0] placedData(memPkg::accSize_t size, logic [31:0] d);
	if (size == memPkg::accByte) begin
		return {d[7:0], d[7:0], d[7:0], d[7:0]};
	end else if (size == memPkg::accHalf) begin
		return {d[15:0], d[15:0]};
	end
	return d;
endfunction

// reference load from the model bytes
function automatic logic [`DATA_W-1:0] loadExpect(memPkg::accSize_t size, logic sgn,
		logic [`ADDR_W-1:0] addr);
	logic [7:0]  a;
	logic [7:0]  hb;
	logic [15:0] h;
	a = addr[7:0];
	hb = {a[7:1], 1'b0};
	h = {mem[hb + 8'd1], mem[hb]};
	if (size == memPkg::accByte) begin
		if (sgn && mem[a][7]) return {24'hFF_FFFF, mem[a]};
		return {24'h00_0000, mem[a]};
	end else if (size == memPkg::accHalf) begin
		if (sgn && h[15]) return {16'hFFFF, h};
		return {16'h0000, h};
	end
	return busWordAt(a);
endfunction

function automatic logic [`ADDR_W-1:0] physOf(logic [`ADDR_W-1:0] virt);
	logic [`ADDR_W-1:0] t;
	t = virt << `SEG_BITS;
	t = t >> `SEG_BITS;
	return {t[`ADDR_W-1:2], 2'b00};
endfunction

task automatic waitIdle();
	int t;
	t = 0;
	while (busy && t < TIMEOUT) begin
		@(negedge clk);
		t++;
	end
	if (busy) timedOut("idle unit before a new request");
endtask

// one full access, bus fields captured while the cycle is open
task automatic doAccess(input logic write, input memPkg::accSize_t size, input logic sgn,
		input logic [31:0] addr, input logic [31:0] data, output logic [31:0] seenAdr,
		output logic [3:0] seenSel, output logic [31:0] seenDat, output logic [31:0] result);
	int t;
	@(negedge clk);
	waitIdle();
	reqValid = 1'b1;
	reqWrite = write;
	reqSize = size;
	reqSigned = sgn;
	reqAddr = addr;
	reqData = data;
	@(negedge clk);
	reqValid = 1'b0;
	t = 0;
	while (!wbStb && t < TIMEOUT) begin
		@(negedge clk);
		t++;
	end
	if (!wbStb) timedOut("wbStb after an accepted request");
	seenAdr = wbAdr;
	seenSel = wbSel;
	seenDat = wbDatW;
	checkValue("wbWe", 32'(write), 32'(wbWe));
	t = 0;
	while (!respValid && t < TIMEOUT) begin
		@(negedge clk);
		t++;
	end
	if (!respValid) timedOut("respValid after the bus cycle");
	result = respData;
endtask

task automatic storeCheck(memPkg::accSize_t size, logic [31:0] addr, logic [31:0] data);
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] dat;
	logic [31:0] res;
	doAccess(1'b1, size, 1'b0, addr, data, adr, sel, dat, res);
	checkValue("wbSel", 32'(laneMask(size, addr[1:0])), 32'(sel));
	checkValue("wbDatW", placedData(size, data), dat);
endtask

task automatic loadCheck(memPkg::accSize_t size, logic sgn, logic [31:0] addr);
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] dat;
	logic [31:0] res;
	doAccess(1'b0, size, sgn, addr, '0, adr, sel, dat, res);
	checkValue("respData", loadExpect(size, sgn, addr), res);
endtask

task automatic idleOutputs();
	checkValue("busy", 32'h0, 32'(busy));
	checkValue("wbCyc", 32'h0, 32'(wbCyc));
	checkValue("wbStb", 32'h0, 32'(wbStb));
	checkValue("respValid", 32'h0, 32'(respValid));
endtask

task automatic resetState();
	repeat (3) begin
		@(negedge clk);
		idleOutputs();
	end
	rst = 1'b0;
	repeat (2) begin
		@(negedge clk);
		idleOutputs();
	end
endtask

task automatic storeLaneRules();
	for (int off = 0; off < 4; off++) begin
		storeCheck(memPkg::accByte, 32'h10 + 32'(off), 32'h5A3C_E100 + 32'(off));
	end
	for (int off = 0; off < 4; off += 2) begin
		storeCheck(memPkg::accHalf, 32'h14 + 32'(off), 32'h1234_8765 ^ 32'(off));
	end
	storeCheck(memPkg::accWord, 32'h18, 32'hDEAD_BEEF);
endtask

task automatic loadExtension();
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] dat;
	logic [31:0] res;
	storeCheck(memPkg::accByte, 32'h20, 32'h81);
	storeCheck(memPkg::accByte, 32'h21, 32'h7F);
	storeCheck(memPkg::accByte, 32'h22, 32'hF0);
	storeCheck(memPkg::accByte, 32'h23, 32'h05);
	storeCheck(memPkg::accWord, 32'h24, 32'h8001_7FFE);
	doAccess(1'b0, memPkg::accWord, 1'b0, 32'h20, '0, adr, sel, dat, res);
	checkValue("respData", 32'h05F0_7F81, res);
	doAccess(1'b0, memPkg::accWord, 1'b1, 32'h24, '0, adr, sel, dat, res);
	checkValue("respData", 32'h8001_7FFE, res);
	for (int base = 32'h20; base <= 32'h24; base += 4) begin
		for (int sgn = 0; sgn < 2; sgn++) begin
			for (int off = 0; off < 4; off++) begin
				loadCheck(memPkg::accByte, 1'(sgn), 32'(base + off));
			end
			for (int off = 0; off < 4; off += 2) begin
				loadCheck(memPkg::accHalf, 1'(sgn), 32'(base + off));
			end
		end
	end
endtask

task automatic addressTranslation();
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] dat;
	logic [31:0] res;
	doAccess(1'b1, memPkg::accWord, 1'b0, 32'hE000_0044, 32'hC0DE_0044, adr, sel, dat, res);
	checkValue("wbAdr", 32'h0000_0044, adr);
	// same physical word through the unmapped alias
	doAccess(1'b0, memPkg::accWord, 1'b0, 32'h0000_0044, '0, adr, sel, dat, res);
	checkValue("respData", 32'hC0DE_0044, res);
	doAccess(1'b0, memPkg::accByte, 1'b1, 32'hFFFF_FF4B, '0, adr, sel, dat, res);
	checkValue("wbAdr", physOf(32'hFFFF_FF4B), adr);
	checkValue("respData", loadExpect(memPkg::accByte, 1'b1, 32'hFFFF_FF4B), res);
endtask

task automatic backPressure();
	int t;
	int startResp;
	int startCyc;
	forcedDelay = 10;
	@(negedge clk);
	waitIdle();
	startResp = respCount;
	startCyc = cycStarts;
	reqValid = 1'b1;
	reqWrite = 1'b0;
	reqSize = memPkg::accWord;
	reqSigned = 1'b0;
	reqAddr = 32'h20;
	@(negedge clk);
	// pipeline holds a second request while the first is stalled
	reqAddr = 32'h30;
	t = 0;
	while (!respValid && t < TIMEOUT) begin
		checkValue("busy", 32'h1, 32'(busy));
		checkValue("wbAdr", 32'h20, wbAdr);
		@(negedge clk);
		t++;
	end
	if (!respValid) timedOut("respValid for the stalled load");
	if (t < 10) begin
		$display("stall ended after %0d cycles, ack came too early", t);
		errorCount++;
	end
	checkValue("respData", loadExpect(memPkg::accWord, 1'b0, 32'h20), respData);
	@(negedge clk);
	reqValid = 1'b0;
	checkValue("wbAdr", 32'h30, wbAdr);
	t = 0;
	while (!respValid && t < TIMEOUT) begin
		@(negedge clk);
		t++;
	end
	if (!respValid) timedOut("respValid for the held request");
	forcedDelay = -1;
	repeat (4) @(negedge clk);
	checkValue("respValid pulses", 32'd2, 32'(respCount - startResp));
	checkValue("wbCyc starts", 32'd2, 32'(cycStarts - startCyc));
endtask

`endif

// ==== verif/memAccessUnitTb.sv ====
`include "memDefines.svh"

module memAccessUnitTb;

	localparam int TIMEOUT = 50;

	logic               clk;
	logic               rst;
	logic               reqValid;
	logic               reqWrite;
	memPkg::accSize_t   reqSize;
	logic               reqSigned;
	logic [`ADDR_W-1:0] reqAddr;
	logic [`DATA_W-1:0] reqData;
	logic               busy;
	logic               respValid;
	logic [`DATA_W-1:0] respData;
	logic               wbCyc;
	logic               wbStb;
	logic               wbWe;
	logic [`ADDR_W-1:0] wbAdr;
	logic [`SEL_W-1:0]  wbSel;
	logic [`DATA_W-1:0] wbDatW;
	logic [`DATA_W-1:0] wbDatR = '0;
	logic               wbAck = 1'b0;

	// memory model state
	logic [7:0] mem [0:255];
	int         waitCnt;
	logic       started;
	int         forcedDelay;

	int   errorCount;
	int   timeoutCount;
	int   respCount = 0;
	int   cycStarts = 0;
	logic prevCyc;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	memAccessUnit memAccessUnit_inst (
		.clk       (clk),
		.rst       (rst),
		.reqValid  (reqValid),
		.reqWrite  (reqWrite),
		.reqSize   (reqSize),
		.reqSigned (reqSigned),
		.reqAddr   (reqAddr),
		.reqData   (reqData),
		.busy      (busy),
		.respValid (respValid),
		.respData  (respData),
		.wbCyc     (wbCyc),
		.wbStb     (wbStb),
		.wbWe      (wbWe),
		.wbAdr     (wbAdr),
		.wbSel     (wbSel),
		.wbDatW    (wbDatW),
		.wbDatR    (wbDatR),
		.wbAck     (wbAck)
	);

	// little endian, lane 0 is the lowest byte
	function automatic logic [`DATA_W-1:0] busWordAt(logic [7:0] byteAddr);
		return {mem[{byteAddr[7:2], 2'd3}], mem[{byteAddr[7:2], 2'd2}],
			mem[{byteAddr[7:2], 2'd1}], mem[{byteAddr[7:2], 2'd0}]};
	endfunction

	// wishbone slave with 0 to 5 cycles of ack latency
	always @(negedge clk) begin
		if (rst) begin
			wbAck <= 1'b0;
			started = 1'b0;
			waitCnt = 0;
			for (int i = 0; i < 256; i++) begin
				mem[8'(i)] = 8'(i * 37 + 11);
			end
		end else if (wbAck) begin
			wbAck <= 1'b0;
			started = 1'b0;
		end else if (wbCyc && wbStb) begin
			if (!started) begin
				started = 1'b1;
				if (forcedDelay >= 0) begin
					waitCnt = forcedDelay;
				end else begin
					waitCnt = int'($urandom % 6);
				end
			end
			if (waitCnt == 0) begin
				if (wbWe && wbSel[0]) mem[{wbAdr[7:2], 2'd0}] = wbDatW[7:0];
				if (wbWe && wbSel[1]) mem[{wbAdr[7:2], 2'd1}] = wbDatW[15:8];
				if (wbWe && wbSel[2]) mem[{wbAdr[7:2], 2'd2}] = wbDatW[23:16];
				if (wbWe && wbSel[3]) mem[{wbAdr[7:2], 2'd3}] = wbDatW[31:24];
				wbDatR <= busWordAt(wbAdr[7:0]);
				wbAck <= 1'b1;
			end else begin
				waitCnt--;
			end
		end
	end

	// response pulses and bus cycle starts
	always @(negedge clk) begin
		if (rst) begin
			prevCyc <= 1'b0;
		end else begin
			if (respValid) begin
				respCount++;
			end
			if (wbCyc && !prevCyc) begin
				cycStarts++;
			end
			prevCyc <= wbCyc;
		end
	end

	task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic timedOut(string what);
		$display("timeout at t=%0t, %s never came", $time, what);
		timeoutCount++;
	endtask

	`include "memAccessTests.svh"

	initial begin
		void'($urandom(58));
		errorCount = 0;
		timeoutCount = 0;
		forcedDelay = -1;
		rst = 1'b1;
		reqValid = 1'b0;
		reqWrite = 1'b0;
		reqSize = memPkg::accWord;
		reqSigned = 1'b0;
		reqAddr = '0;
		reqData = '0;
		resetState();
		storeLaneRules();
		loadExtension();
		addressTranslation();
		backPressure();
		$display("value errors: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
